/* all.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_select.sv
rtl/fetch_prefetch_buffer.sv
rtl/fetch_rvc_expander.sv
rtl/fetch_if_stage.sv
test/fetch_imem.sv
test/fetch_sva.sv
test/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_pc_select.sv
      - rtl/fetch_prefetch_buffer.sv
      - rtl/fetch_rvc_expander.sv
      - rtl/fetch_if_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/fetch_imem.sv
      - test/fetch_sva.sv
      - test/fetch_tb.sv

/* test/fetch_tb.sv */
`include "fetch_consts.svh"

module fetch_tb
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;  // cycles allowed per wait

  // one redirect and what should come out of it
  typedef struct packed {
    pc_mux_e          pc_mux;
    exc_pc_mux_e      exc_pc_mux;
    logic [4:0]       exc_cause;
    logic             backpress;  // random id_ready / halt
    logic [3:0]       n_instr;
    logic [2:0]       n_words;    // words placed at the start pc
    logic [0:3][31:0] words;
  } scenario_t;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        halt_if;
  logic        id_ready;
  logic        clear_instr_valid;
  pc_ctrl_t    pc_ctrl;
  pc_targets_t pc_targets;
  ibus_req_t   ibus_req;
  ibus_rsp_t   ibus_rsp;
  if_id_t      if_id;
  logic [31:0] pc_if;
  logic        if_busy;
  scenario_t   scen [9];
  logic [31:0] exp_pc;    // next pc of the current stream
  logic [31:0] last_pc;   // pc last loaded into IF/ID
  logic [31:0] head_pc;   // pc_if_o at the last negedge
  logic        head_busy; // if_busy_o at the last negedge
  integer      seed;

  fetch_if_stage UUT (
    .clk (clk), .rst_n (rst_n), .req_i (req), .halt_if_i (halt_if), .id_ready_i (id_ready),
    .clear_instr_valid_i (clear_instr_valid), .pc_ctrl_i (pc_ctrl), .pc_targets_i (pc_targets),
    .ibus_req_o (ibus_req), .ibus_rsp_i (ibus_rsp), .if_id_o (if_id), .pc_if_o (pc_if),
    .if_busy_o (if_busy)
  );

  fetch_imem imem (.clk (clk), .rst_n (rst_n), .ibus_req_i (ibus_req), .ibus_rsp_o (ibus_rsp));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic if_id_t expected_item(input logic [31:0] pc, input logic [31:0] w);
    if_id_t      e;
    logic [31:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    imm = {{26{w[12]}}, w[12], w[6:2]};  // 6 bit signed immediate
    rd  = w[11:7];
    rs2 = w[6:2];
    e   = '{valid: 1'b1, instr: `INSTR_NOP, pc: pc, is_compressed: (w[1:0] != 2'b11),
            illegal_c: 1'b0};
    if (!e.is_compressed) e.instr = w;
    else if (w[1:0] == 2'b01 && w[15:13] == 3'b000)  // c.addi, c.nop
      e.instr = {imm[11:0], rd, 3'b000, rd, `OPC_OP_IMM};
    else if (w[1:0] == 2'b01 && w[15:13] == 3'b010)  // c.li
      e.instr = {imm[11:0], 5'd0, 3'b000, rd, `OPC_OP_IMM};
    else if (w[1:0] == 2'b10 && w[15:13] == 3'b100 && rs2 != 5'd0)  // c.mv, c.add
      e.instr = {7'd0, rs2, (w[12] ? rd : 5'd0), 3'b000, rd, `OPC_OP};
    else if (w[1:0] == 2'b10 && w[15:13] == 3'b100 && rd != 5'd0)   // c.jr, c.jalr
      e.instr = {12'd0, rd, 3'b000, 4'd0, w[12], `OPC_JALR};
    else e.illegal_c = 1'b1;  // everything else becomes a nop
    return e;
  endfunction

  function automatic logic [31:0] start_pc(input scenario_t sc);
    logic [31:0] base;
    base = {pc_targets.trap_base, 8'h00};
    case (sc.pc_mux)
      PC_JUMP:   return pc_targets.jump_target_id;
      PC_BRANCH: return pc_targets.jump_target_ex;
      PC_MRET:   return pc_targets.mepc;
      PC_DRET:   return pc_targets.depc;
      PC_FENCEI: return last_pc + 32'd4;
      PC_EXCEPTION: begin
        if (sc.exc_pc_mux == EXC_PC_IRQ) return base + {27'd0, sc.exc_cause} * 32'd4;
        if (sc.exc_pc_mux == EXC_PC_DBD) return {pc_targets.dm_halt_addr, 2'b00};
        return base;
      end
      default:   return pc_targets.boot_addr;
    endcase
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic compare_if_id(input string name, input if_id_t got, input if_id_t want);
    if (got !== want) begin
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic compare_addr(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, want);
      abort_run();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch at %0t: %s = %b, expected %b", $time, name, got, want);
      abort_run();
    end
  endtask

  // bound protocol assertions
  always @(negedge clk) begin
    if (UUT.u_sva.err_cnt != 0) begin
      $display("%0d protocol assertions failed", UUT.u_sva.err_cnt);
      abort_run();
    end
  end

  // buffer head as seen before the next edge
  task automatic sample_head();
    head_pc   = pc_if;
    head_busy = if_busy;
  endtask

  // the word just loaded must be the next one of the stream
  task automatic check_item();
    compare_addr("pc_if_o", head_pc, exp_pc);    // head before the load
    compare_flag("if_busy_o", head_busy, 1'b1);  // a buffered word keeps it busy
    compare_if_id("if_id_o", if_id, expected_item(exp_pc, imem.mem[exp_pc[11:2]]));
    last_pc = exp_pc;
    exp_pc  = exp_pc + 32'd4;
  endtask

  // clear_instr_valid_i stays high, so valid at a negedge means a fresh load
  task automatic next_instr(input logic backpress);
    int cycles;
    cycles = 0;
    sample_head();
    do begin
      @(posedge clk);
      id_ready <= backpress ? (($random(seed) & 3) != 0) : 1'b1;
      halt_if  <= backpress ? (($random(seed) & 7) == 0) : 1'b0;
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: no instruction reached IF/ID within %0d cycles", TIMEOUT);
        abort_run();
      end
      if (if_id.valid) check_item();
      sample_head();
    end while (!if_id.valid);
  endtask

  task automatic wait_valid();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: if_id_o.valid stayed low for %0d cycles", TIMEOUT);
        abort_run();
      end
    end while (!if_id.valid);
  endtask

  // boot by raising req, otherwise one pc_set cycle
  task automatic start_stream(input scenario_t sc, input logic boot);
    @(posedge clk);
    if (boot) req <= 1'b1;
    else pc_ctrl <= '{pc_set: 1'b1, pc_mux: sc.pc_mux, exc_pc_mux: sc.exc_pc_mux,
                      exc_cause: sc.exc_cause};
    @(negedge clk);
    if (if_id.valid) check_item();  // old stream word loaded on that edge
    exp_pc = start_pc(sc);
    for (int w = 0; w < sc.n_words; w++) imem.mem[exp_pc[11:2] + w] = sc.words[w];
    @(posedge clk);
    pc_ctrl.pc_set <= 1'b0;
    @(negedge clk);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    seed              = 82785;
    rst_n             = 1'b0;
    req               = 1'b0;
    halt_if           = 1'b0;
    id_ready          = 1'b1;
    clear_instr_valid = 1'b1;
    pc_ctrl    = '{pc_set: 1'b0, pc_mux: PC_BOOT, exc_pc_mux: EXC_PC_EXCEPTION, exc_cause: 5'd0};
    pc_targets = '{boot_addr: 32'h080, jump_target_id: 32'h200, jump_target_ex: 32'h300,
                   mepc: 32'h400, depc: 32'h500, trap_base: 24'h8, dm_halt_addr: 30'h380};
    last_pc   = '0;
    exp_pc    = '0;
    head_pc   = '0;
    head_busy = 1'b0;
    // c.nop c.addi c.li c.mv, then c.add c.jr c.jalr c.ebreak, then illegal forms
    scen[0] = '{PC_BOOT, EXC_PC_EXCEPTION, 5'd0, 1'b0, 4'd5, 3'd0, '0};
    scen[1] = '{PC_JUMP, EXC_PC_EXCEPTION, 5'd0, 1'b0, 4'd6, 3'd4,
                {32'hABCD_0001, 32'h0000_12F5, 32'hFFFF_451D, 32'h1234_8426}};
    scen[2] = '{PC_BRANCH, EXC_PC_EXCEPTION, 5'd0, 1'b1, 4'd6, 3'd4,
                {32'h0000_9426, 32'h5555_8082, 32'h0000_9302, 32'h0000_9002}};
    scen[3] = '{PC_EXCEPTION, EXC_PC_EXCEPTION, 5'd0, 1'b0, 4'd4, 3'd3,
                {32'h0000_0000, 32'h0000_A001, 32'h0040_0093, 32'h0}};
    scen[4] = '{PC_EXCEPTION, EXC_PC_IRQ, 5'd5, 1'b1, 4'd4, 3'd0, '0};
    scen[5] = '{PC_EXCEPTION, EXC_PC_DBD, 5'd0, 1'b0, 4'd4, 3'd0, '0};
    scen[6] = '{PC_MRET, EXC_PC_EXCEPTION, 5'd0, 1'b1, 4'd5, 3'd0, '0};
    scen[7] = '{PC_DRET, EXC_PC_EXCEPTION, 5'd0, 1'b0, 4'd4, 3'd0, '0};
    scen[8] = '{PC_FENCEI, EXC_PC_EXCEPTION, 5'd0, 1'b1, 4'd5, 3'd0, '0};
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_flag("ibus_req_o.req", ibus_req.req, 1'b0);  // idle out of reset
    compare_flag("if_id_o.valid", if_id.valid, 1'b0);
    compare_flag("if_busy_o", if_busy, 1'b0);

    for (int s = 0; s < 9; s++) begin
      start_stream(scen[s], s == 0);
      for (int i = 0; i < scen[s].n_instr; i++) begin
        next_instr(scen[s].backpress);
      end
    end

    // hold without clear, then clear without a load
    @(posedge clk);
    clear_instr_valid <= 1'b0;
    id_ready          <= 1'b1;
    halt_if           <= 1'b0;
    wait_valid();
    @(posedge clk);
    id_ready <= 1'b0;
    @(negedge clk);
    compare_flag("if_id_o.valid", if_id.valid, 1'b1);
    @(posedge clk);
    clear_instr_valid <= 1'b1;
    @(negedge clk);
    compare_flag("if_id_o.valid", if_id.valid, 1'b1);  // held, no load and no clear
    @(posedge clk);
    @(negedge clk);
    compare_flag("if_id_o.valid", if_id.valid, 1'b0);

    if (UUT.u_sva.err_cnt != 0) begin
      $display("%0d protocol assertions failed", UUT.u_sva.err_cnt);
      abort_run();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

/* test/fetch_sva.sv */
module fetch_sva
  import fetch_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input ibus_req_t ibus_req_i,
  input ibus_rsp_t ibus_rsp_i,
  input if_id_t    if_id_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int   err_cnt = 0;  // failed assertion count, read at the end of the run
  logic acc_seen;     // some request was granted since reset

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) acc_seen <= 1'b0;
    else if (ibus_req_i.req && ibus_rsp_i.gnt) acc_seen <= 1'b1;
  end

  // held request keeps its address until granted
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_req_i.req && !ibus_rsp_i.gnt |=> ibus_req_i.req && $stable(ibus_req_i.addr))
    else begin err_cnt++; $error("ibus request dropped or moved before its grant"); end

  no_req_in_reset: assert property (@(posedge clk) !rst_n |-> !ibus_req_i.req)
    else begin err_cnt++; $error("ibus request raised during reset"); end

  valid_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(if_id_i.valid) |-> acc_seen)
    else begin err_cnt++; $error("if_id valid rose before any granted request"); end

endmodule

bind fetch_if_stage fetch_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .ibus_req_i (ibus_req_o),
  .ibus_rsp_i (ibus_rsp_i),
  .if_id_i    (if_id_o)
);

/* test/fetch_imem.sv */
module fetch_imem
  import fetch_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  ibus_req_t ibus_req_i,
  output ibus_rsp_t ibus_rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] mem [1024];  // 4 KiB, word addressed
  logic [31:0] data_q [$];  // accepted requests waiting for rvalid
  int          dly_q [$];   // extra cycles before each response
  logic [1:0]  gnt_wait;    // cycles until the next grant
  logic        rvalid;
  logic [31:0] rdata;
  integer      seed;

  initial begin
    seed = 82785;
    // plain 32-bit words that carry their own word address
    for (int i = 0; i < 1024; i++) mem[i] = {i[9:0], 10'h000, i[9:0], 2'b11};
  end

  assign ibus_rsp_o = '{gnt: ibus_req_i.req & (gnt_wait == 2'd0), rvalid: rvalid,
                        rdata: rdata, err: 1'b0};

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait <= 2'd0;
      rvalid   <= 1'b0;
      rdata    <= '0;
      data_q.delete();
      dly_q.delete();
    end else begin
      rvalid <= 1'b0;
      if (data_q.size() != 0) begin  // responses leave in order
        if (dly_q[0] == 0) begin
          rvalid <= 1'b1;
          rdata  <= data_q.pop_front();
          void'(dly_q.pop_front());
        end else begin
          dly_q[0] = dly_q[0] - 1;
        end
      end
      if (ibus_req_i.req && gnt_wait == 2'd0) begin  // accepted this cycle
        data_q.push_back(mem[ibus_req_i.addr[11:2]]);
        dly_q.push_back($random(seed) & 3);
        gnt_wait <= 2'($random(seed));
      end else if (ibus_req_i.req) begin
        gnt_wait <= gnt_wait - 2'd1;  // grant delay counts only while requested
      end
    end
  end

endmodule

/* rtl/fetch_if_stage.sv */
module fetch_if_stage
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,                // fetch enable from the controller
  input  logic        halt_if_i,
  input  logic        id_ready_i,
  input  logic        clear_instr_valid_i,
  input  pc_ctrl_t    pc_ctrl_i,
  input  pc_targets_t pc_targets_i,
  output ibus_req_t   ibus_req_o,
  input  ibus_rsp_t   ibus_rsp_i,
  output if_id_t      if_id_o,
  output logic [31:0] pc_if_o,
  output logic        if_busy_o
);

  enum logic [0:0] {IDLE, WAIT} state_q, state_d;  // offset fsm

  logic [31:0] branch_addr;
  logic        branch_req;
  logic        fetch_valid;  // buffer head valid
  logic        fetch_ready;  // pop the head
  fetch_item_t fetch_item;
  logic        if_load;      // IF/ID register takes the head this cycle
  logic [31:0] instr_exp;
  logic        is_c;
  logic        illegal_c;

  // IF/ID register
  logic        valid_q;
  logic [31:0] instr_q;
  logic [31:0] pc_q;
  logic        is_c_q;
  logic        illegal_c_q;

  fetch_pc_select u_pc_select (
    .targets_i     (pc_targets_i),
    .ctrl_i        (pc_ctrl_i),
    .pc_id_i       (pc_q),
    .branch_addr_o (branch_addr)
  );

  fetch_prefetch_buffer u_prefetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_req),
    .branch_addr_i (branch_addr),
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_item_o  (fetch_item),
    .ibus_req_o    (ibus_req_o),
    .ibus_rsp_i    (ibus_rsp_i),
    .busy_o        (if_busy_o)
  );

  fetch_rvc_expander u_rvc_expander (
    .instr_i         (fetch_item.rdata),
    .instr_o         (instr_exp),
    .is_compressed_o (is_c),
    .illegal_c_o     (illegal_c)
  );

  ////////////////////////////////////////
  // offset fsm
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    branch_req = 1'b0;
    unique case (state_q)
      IDLE: if (req_i) begin  // first fetch after boot, assume aligned
        branch_req = 1'b1;
        state_d    = WAIT;
      end
      WAIT: state_d = WAIT;  // serving words from the buffer
      default: state_d = IDLE;
    endcase
    if (pc_ctrl_i.pc_set) begin  // redirect wins from any state
      branch_req = 1'b1;
      state_d    = WAIT;
    end
  end

  // head goes to ID only when nothing redirects this cycle
  assign if_load = (state_q == WAIT) & fetch_valid & ~pc_ctrl_i.pc_set
                 & req_i & id_ready_i & ~halt_if_i;
  assign fetch_ready = if_load;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (if_load) valid_q <= 1'b1;
      else if (clear_instr_valid_i) valid_q <= 1'b0;  // ID consumed it, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (if_load) begin
      instr_q     <= instr_exp;
      pc_q        <= fetch_item.addr;
      is_c_q      <= is_c;
      illegal_c_q <= illegal_c;
    end
  end

  assign if_id_o = '{valid: valid_q, instr: instr_q, pc: pc_q,
                     is_compressed: is_c_q, illegal_c: illegal_c_q};
  assign pc_if_o = fetch_item.addr;  // pc of the buffer head

endmodule

/* rtl/fetch_rvc_expander.sv */
`include "fetch_consts.svh"

module fetch_rvc_expander
  import fetch_pkg::*;
(
  input  instr_u      instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_c_o
);

  instr_u      exp;     // expanded word, built through the rv32 view
  logic [11:0] imm;     // sign extended 6 bit immediate
  logic [4:0]  rd_rs1;
  logic [4:0]  rs2;

  assign rd_rs1 = instr_i.rvc.rd_rs1;
  assign rs2    = instr_i.rvc.rs2_imm;
  assign imm    = {{6{instr_i.rvc.bit12}}, instr_i.rvc.bit12, instr_i.rvc.rs2_imm};

  assign is_compressed_o = (instr_i.rv32.opcode[1:0] != 2'b11);

  always_comb begin
    exp         = instr_i;  // 32 bit instrs pass through
    illegal_c_o = 1'b0;

    if (is_compressed_o) begin
      exp         = `INSTR_NOP;
      illegal_c_o = 1'b1;  // cleared by each supported form

      unique case ({instr_i.rvc.op, instr_i.rvc.funct3})
        // c.addi / c.nop -> addi rd, rd, imm
        // c.li           -> addi rd, x0, imm
        5'b01_000, 5'b01_010: begin
          exp.rv32    = '{funct7: imm[11:5], rs2: imm[4:0],
                          rs1: (instr_i.rvc.funct3 == 3'b010) ? 5'd0 : rd_rs1,
                          funct3: 3'b000, rd: rd_rs1, opcode: `OPC_OP_IMM};
          illegal_c_o = 1'b0;
        end
        // c.jr c.mv c.ebreak c.jalr c.add
        5'b10_100: begin
          if (rs2 != 5'd0) begin
            // c.mv -> add rd, x0, rs2 , c.add -> add rd, rd, rs2
            exp.rv32    = '{funct7: 7'd0, rs2: rs2,
                            rs1: instr_i.rvc.bit12 ? rd_rs1 : 5'd0,
                            funct3: 3'b000, rd: rd_rs1, opcode: `OPC_OP};
            illegal_c_o = 1'b0;
          end else if (rd_rs1 != 5'd0) begin
            // c.jr -> jalr x0, 0(rs1) , c.jalr -> jalr x1, 0(rs1)
            exp.rv32    = '{funct7: 7'd0, rs2: 5'd0, rs1: rd_rs1, funct3: 3'b000,
                            rd: {4'd0, instr_i.rvc.bit12}, opcode: `OPC_JALR};
            illegal_c_o = 1'b0;
          end
          // rs1 == 0 is c.ebreak or reserved, left illegal
        end
        default: begin
          // unsupported rvc form
        end
      endcase
    end
  end

  assign instr_o = exp;

endmodule

/* rtl/fetch_prefetch_buffer.sv */
`include "fetch_consts.svh"

module fetch_prefetch_buffer
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,          // fetching enabled
  input  logic        branch_i,       // redirect, flush and restart
  input  logic [31:0] branch_addr_i,
  input  logic        fetch_ready_i,  // pop the head
  output logic        fetch_valid_o,
  output fetch_item_t fetch_item_o,
  output ibus_req_t   ibus_req_o,
  input  ibus_rsp_t   ibus_rsp_i,     // err is carried but not acted on
  output logic        busy_o
);

  logic [31:0] br_addr;     // branch target, halfword aligned
  logic [31:0] addr_q;      // address of the next or held request
  logic [31:0] tgt_q;       // redirect target parked behind a stale held request
  logic [31:0] rsp_addr_q;  // address tag for the next kept response
  logic        pend_q;      // request on the bus last cycle without gnt
  logic        stale_q;     // held request belongs to a flushed stream
  logic [1:0]  out_cnt_q;   // accepted, rvalid not seen yet
  logic [1:0]  disc_cnt_q;  // outstanding responses to throw away
  logic [1:0]  fifo_cnt_q;
  logic        wr_ptr_q;
  logic        rd_ptr_q;
  fetch_item_t fifo_q [`FETCH_FIFO_DEPTH];
  logic [2:0]  used;        // slots claimed by outstanding reqs and fifo words
  logic        issue;
  logic        accept;
  logic        stale_acc;   // accepted request whose data will be dropped
  logic        drop;
  logic        push;
  logic        pop;

  assign br_addr = {branch_addr_i[31:1], 1'b0};

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  // fifo is emptied by a branch, so only outstanding reqs count then
  assign used  = {1'b0, out_cnt_q} + (branch_i ? 3'd0 : {1'b0, fifo_cnt_q});
  assign issue = pend_q | (req_i & (used < 3'(`FETCH_FIFO_DEPTH)));

  assign ibus_req_o.req  = issue;
  // a held request keeps its address, a branch goes out at once otherwise
  assign ibus_req_o.addr = (branch_i & ~pend_q) ? br_addr : addr_q;

  assign accept    = issue & ibus_rsp_i.gnt;
  assign stale_acc = accept & (stale_q | (pend_q & branch_i));

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////

  assign drop = ibus_rsp_i.rvalid & (disc_cnt_q != 2'd0);
  assign push = ibus_rsp_i.rvalid & ~drop & ~branch_i;  // old stream word on branch is lost
  assign pop  = fetch_ready_i & fetch_valid_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q     <= '0;
      rsp_addr_q <= '0;
      pend_q     <= 1'b0;
      stale_q    <= 1'b0;
      out_cnt_q  <= '0;
      disc_cnt_q <= '0;
      fifo_cnt_q <= '0;
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
    end else begin
      pend_q    <= issue & ~ibus_rsp_i.gnt;
      out_cnt_q <= out_cnt_q + {1'b0, accept} - {1'b0, ibus_rsp_i.rvalid};

      if (branch_i) begin
        // everything still in flight is from the old stream
        disc_cnt_q <= out_cnt_q - {1'b0, ibus_rsp_i.rvalid} + {1'b0, stale_acc};
        rsp_addr_q <= br_addr;
        fifo_cnt_q <= '0;
        wr_ptr_q   <= 1'b0;
        rd_ptr_q   <= 1'b0;
      end else begin
        disc_cnt_q <= disc_cnt_q - {1'b0, drop} + {1'b0, stale_acc};
        fifo_cnt_q <= fifo_cnt_q + {1'b0, push} - {1'b0, pop};
        if (push) begin
          rsp_addr_q <= rsp_addr_q + 32'd4;  // stream is sequential
          wr_ptr_q   <= ~wr_ptr_q;
        end
        if (pop) rd_ptr_q <= ~rd_ptr_q;
      end

      if (accept) begin
        // after a stale grant resume at the redirect target
        addr_q <= stale_acc ? (branch_i ? br_addr : tgt_q) : ibus_req_o.addr + 32'd4;
      end else if (branch_i & ~pend_q) begin
        addr_q <= br_addr;  // not granted yet, keep it on the bus
      end

      if (accept) stale_q <= 1'b0;
      else if (branch_i & pend_q) stale_q <= 1'b1;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (branch_i) tgt_q <= br_addr;
    if (push) fifo_q[wr_ptr_q] <= '{rdata: ibus_rsp_i.rdata, addr: rsp_addr_q};
  end

  assign fetch_valid_o = (fifo_cnt_q != 2'd0);
  assign fetch_item_o  = fifo_q[rd_ptr_q];
  assign busy_o        = (out_cnt_q != 2'd0) | fetch_valid_o;

endmodule

/* rtl/fetch_pc_select.sv */
module fetch_pc_select
  import fetch_pkg::*;
(
  input  pc_targets_t targets_i,
  input  pc_ctrl_t    ctrl_i,
  input  logic [31:0] pc_id_i,        // pc of the instr in IF/ID, for fence.i
  output logic [31:0] branch_addr_o
);

  logic [31:0] exc_pc;  // trap entry address

  ////////////////////////////////////////
  // trap entry
  ////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.exc_pc_mux)
      EXC_PC_EXCEPTION: begin
        exc_pc = {targets_i.trap_base, 8'h00};  // all exceptions share the base
      end
      EXC_PC_IRQ: begin
        // base + 4 * cause, cause fits in the low byte
        exc_pc = {targets_i.trap_base, 1'b0, ctrl_i.exc_cause, 2'b00};
      end
      EXC_PC_DBD: begin
        exc_pc = {targets_i.dm_halt_addr, 2'b00};
      end
      default: begin
        exc_pc = {targets_i.trap_base, 8'h00};
      end
    endcase
  end

  ////////////////////////////////////////
  // next fetch address
  ////////////////////////////////////////

  always_comb begin
    branch_addr_o = targets_i.boot_addr;  // boot is the fallback
    unique case (ctrl_i.pc_mux)
      PC_BOOT:      branch_addr_o = targets_i.boot_addr;
      PC_JUMP:      branch_addr_o = targets_i.jump_target_id;  // jal / jalr in decode
      PC_BRANCH:    branch_addr_o = targets_i.jump_target_ex;  // taken branch in ex
      PC_EXCEPTION: branch_addr_o = exc_pc;
      PC_MRET:      branch_addr_o = targets_i.mepc;
      PC_DRET:      branch_addr_o = targets_i.depc;
      // refetch from the instr after fence.i so the buffer reloads
      PC_FENCEI:    branch_addr_o = pc_id_i + 32'd4;
      default:      branch_addr_o = targets_i.boot_addr;
    endcase
  end

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

  ////////////////////////////////////////
  // pc mux selects
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101,
    PC_DRET      = 3'b111
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,  // sync trap, base address
    EXC_PC_IRQ       = 2'b01,  // vectored interrupt
    EXC_PC_DBD       = 2'b10   // debug halt entry
  } exc_pc_mux_e;

  // candidate fetch addresses from the rest of the core
  typedef struct packed {
    logic [31:0] boot_addr;
    logic [31:0] jump_target_id;  // from decode
    logic [31:0] jump_target_ex;  // from execute
    logic [31:0] mepc;
    logic [31:0] depc;
    logic [23:0] trap_base;       // mtvec[31:8]
    logic [29:0] dm_halt_addr;    // word address
  } pc_targets_t;

  typedef struct packed {
    logic        pc_set;
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_pc_mux;
    logic [4:0]  exc_cause;  // irq vector index
  } pc_ctrl_t;

  ////////////////////////////////////////
  // instruction bus
  ////////////////////////////////////////

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } ibus_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;  // not acted on
  } ibus_rsp_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
  } fetch_item_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        is_compressed;
    logic        illegal_c;
  } if_id_t;

  ////////////////////////////////////////
  // one fetched word, two decodings
  ////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv32_t;

  typedef struct packed {
    logic [15:0] upper;    // ignored in the rvc view
    logic [2:0]  funct3;
    logic        bit12;
    logic [4:0]  rd_rs1;
    logic [4:0]  rs2_imm;
    logic [1:0]  op;
  } rvc_t;

  typedef union packed {
    rv32_t rv32;
    rvc_t  rvc;
  } instr_u;

endpackage

/* rtl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////////////////////////
// prefetch buffer sizing
////////////////////////////////////////

// fifo entries, also the cap on outstanding bus requests
`define FETCH_FIFO_DEPTH 2

////////////////////////////////////////
// instruction encodings
////////////////////////////////////////

`define INSTR_NOP 32'h0000_0013  // addi x0, x0, 0

// major opcodes produced by the rvc expander
`define OPC_OP_IMM 7'h13  // addi
`define OPC_OP     7'h33  // add
`define OPC_JALR   7'h67  // jalr

`endif
